/* Bender.yml */
package:
  name: div_serial

sources:
  # packages first, the RTL imports them
  - common/div_cfg_pkg.sv
  - common/div_op_pkg.sv
  - div/div_prep.sv
  - div/div_core.sv
  - div/div_ctrl.sv
  - rtl/div_top.sv
  - target: simulation
    files:
      - verif/div_clk_gen.sv
      - verif/div_tb.sv

/* common/div_cfg_pkg.sv */
////////////////////
// divider configuration shared by RTL and testbench
// default datapath width and the controller state encoding
////////////////////

package div_cfg_pkg;

  ////////////////////
  // sizing
  ////////////////////

  // one machine word
  localparam int DIV_XLEN_DEFAULT = 32;

  ////////////////////
  // controller states
  ////////////////////

  typedef enum logic [1:0] {
    ST_CHK = 2'b00, // idle, checking for issue
    ST_DIV = 2'b01, // iterating
    ST_RES = 2'b10  // result ready, waiting on memory stage
  } div_state_e;

endpackage

/* common/div_op_pkg.sv */
////////////////////
// decoded divide operation codes
// bit 0 selects unsigned, bit 1 selects remainder
////////////////////

package div_op_pkg;

  ////////////////////
  // bit meanings
  ////////////////////

  localparam int OP_UNSIGNED_BIT = 0; // set for DIVU / REMU
  localparam int OP_REM_BIT      = 1; // set for REM / REMU

  ////////////////////
  // operation codes
  ////////////////////

  typedef enum logic [1:0] {
    OP_DIV  = 2'b00, // signed quotient
    OP_DIVU = 2'b01, // unsigned quotient
    OP_REM  = 2'b10, // signed remainder
    OP_REMU = 2'b11  // unsigned remainder
  } div_op_e;

  // both bits line up with the bit positions above
  // so op[OP_REM_BIT] picks remainder vs quotient directly

endpackage

/* div/div_core.sv */
////////////////////
// bit-serial restoring divide core on unsigned magnitudes
// start_i loads the operands, then MXLEN steps follow one per cycle
// last_o is high in the cycle of the final step
////////////////////

`timescale 1ns/1ps

module div_core #(
  parameter int MXLEN = 32
)
(
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             start_i,
  input  logic [MXLEN-1:0] dividend_i,
  input  logic [MXLEN-1:0] divisor_i,

  output logic             last_o,
  output logic [MXLEN-1:0] quotient_o,
  output logic [MXLEN-1:0] remainder_o
);

  localparam int CNT_W = $clog2(MXLEN);

  logic             busy;
  logic [CNT_W-1:0] cnt;     // steps left minus one
  logic [MXLEN-1:0] p;       // partial remainder
  logic [MXLEN-1:0] a;       // dividend shifting out, quotient shifting in
  logic [MXLEN-1:0] b;       // divisor
  logic [MXLEN  :0] p_shift; // one extra bit, divisor may use the msb
  logic [MXLEN  :0] diff;

  assign p_shift = {p, a[MXLEN-1]};
  assign diff    = p_shift - {1'b0, b};

  assign last_o = busy && (cnt == '0);

  ////////////////////
  // step control
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      busy <= 1'b0;
      cnt  <= '0;
    end
    else if (start_i)
    begin
      busy <= 1'b1;
      cnt  <= CNT_W'(MXLEN-1);
    end
    else if (busy)
    begin
      cnt <= cnt - 1'b1;
      if (cnt == '0) busy <= 1'b0;
    end

  // datapath
  always_ff @(posedge clk_i)
    if (start_i)
    begin
      p <= '0;
      a <= dividend_i;
      b <= divisor_i;
    end
    else if (busy)
    begin
      if (diff[MXLEN]) p <= p_shift[MXLEN-1:0]; // negative, restore
      else             p <= diff[MXLEN-1:0];
      a <= {a[MXLEN-2:0], ~diff[MXLEN]};          // quotient bit in
    end

  assign quotient_o  = a;
  assign remainder_o = p;

endmodule

/* div/div_ctrl.sv */
////////////////////
// divider sequencing FSM and result register
// accepts issues in the check state, returns early results directly,
// otherwise runs the core and applies the sign fix-up on the way out
////////////////////

`timescale 1ns/1ps

module div_ctrl
  import div_op_pkg::*;
  import div_cfg_pkg::*;
#(
  parameter int MXLEN = 32
)
(
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             issue_i,
  input  logic             ex_stall_i,
  input  logic             mem_stall_i,
  input  div_op_e          op_i,

  // from operand preparation
  input  logic             special_i,
  input  logic [MXLEN-1:0] special_val_i,
  input  logic             neg_q_i,
  input  logic             neg_r_i,

  // from core
  input  logic             last_i,
  input  logic [MXLEN-1:0] quotient_i,
  input  logic [MXLEN-1:0] remainder_i,

  output logic             start_o,
  output logic [MXLEN-1:0] div_r_o,
  output logic             div_bubble_o,
  output logic             div_stall_o
);

  div_state_e       state;
  logic             accept;
  logic             res_load;
  div_op_e          op_q;   // op in flight
  logic             neg_q_q;
  logic             neg_r_q;
  logic             neg_sel;
  logic [MXLEN-1:0] res_sel;
  logic [MXLEN-1:0] res_val;

  assign accept   = (state == ST_CHK) && issue_i && !ex_stall_i;
  assign res_load = (state == ST_RES) && !mem_stall_i;
  assign start_o  = accept && !special_i; // core only for real divisions

  ////////////////////
  // result select and sign fix-up
  ////////////////////

  assign res_sel = op_q[OP_REM_BIT] ? remainder_i : quotient_i;
  assign neg_sel = op_q[OP_REM_BIT] ? neg_r_q : neg_q_q;
  assign res_val = neg_sel ? (~res_sel + 1'b1) : res_sel;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      state        <= ST_CHK;
      div_bubble_o <= 1'b1;
      div_stall_o  <= 1'b0;
    end
    else
    begin
      div_bubble_o <= 1'b1; // single cycle low pulse
      unique case (state)
        ST_CHK:
          if (accept)
          begin
            if (special_i)
            begin
              div_bubble_o <= 1'b0; // early result, no stall
            end
            else
            begin
              state       <= ST_DIV;
              div_stall_o <= 1'b1;
            end
          end
        ST_DIV:
          if (last_i) state <= ST_RES;
        ST_RES:
          if (!mem_stall_i)
          begin
            state        <= ST_CHK;
            div_bubble_o <= 1'b0;
            div_stall_o  <= 1'b0;
          end
        default: state <= ST_CHK;
      endcase
    end

  // op, flags and result
  always_ff @(posedge clk_i)
    if (accept)
    begin
      op_q    <= op_i;
      neg_q_q <= neg_q_i;
      neg_r_q <= neg_r_i;
      if (special_i) div_r_o <= special_val_i;
    end
    else if (res_load)
    begin
      div_r_o <= res_val;
    end

endmodule

/* div/div_prep.sv */
////////////////////
// divider operand preparation, purely combinational
// flags divide by zero and signed overflow with their early result,
// otherwise hands magnitudes and sign fix-up flags onwards
////////////////////

`timescale 1ns/1ps

module div_prep
  import div_op_pkg::*;
#(
  parameter int MXLEN = 32
)
(
  input  div_op_e          op_i,
  input  logic [MXLEN-1:0] opa_i,
  input  logic [MXLEN-1:0] opb_i,

  output logic             special_o,
  output logic [MXLEN-1:0] special_val_o,
  output logic             neg_q_o,
  output logic             neg_r_o,
  output logic [MXLEN-1:0] dividend_o,
  output logic [MXLEN-1:0] divisor_o
);

  logic             is_unsigned;
  logic             is_rem;
  logic             div_zero;
  logic             sgn_ovf;
  logic             sign_a;
  logic             sign_b;
  logic [MXLEN-1:0] most_neg;

  assign is_unsigned = op_i[OP_UNSIGNED_BIT];
  assign is_rem      = op_i[OP_REM_BIT];

  assign most_neg = {1'b1, {(MXLEN-1){1'b0}}}; // -2^(MXLEN-1)

  ////////////////////
  // special cases
  ////////////////////

  assign div_zero = ~|opb_i;
  // most negative / -1 only overflows for signed ops
  assign sgn_ovf  = !is_unsigned && (opa_i == most_neg) && (&opb_i);

  assign special_o = div_zero | sgn_ovf;

  always_comb
  begin
    special_val_o = '0;
    if (div_zero)
    begin
      special_val_o = is_rem ? opa_i : {MXLEN{1'b1}}; // q = all ones, r = dividend
    end
    else if (sgn_ovf)
    begin
      special_val_o = is_rem ? '0 : opa_i; // q = dividend, r = 0
    end
  end

  ////////////////////
  // magnitudes and signs
  ////////////////////

  assign sign_a = !is_unsigned && opa_i[MXLEN-1];
  assign sign_b = !is_unsigned && opb_i[MXLEN-1];

  assign neg_q_o = sign_a ^ sign_b; // signs differ
  assign neg_r_o = sign_a;          // remainder follows dividend

  // abs of most_neg wraps to 2^(MXLEN-1), still fine as unsigned magnitude
  assign dividend_o = sign_a ? (~opa_i + 1'b1) : opa_i;
  assign divisor_o  = sign_b ? (~opb_i + 1'b1) : opb_i;

endmodule

/* filelist.f */
common/div_cfg_pkg.sv
common/div_op_pkg.sv
div/div_prep.sv
div/div_core.sv
div/div_ctrl.sv
rtl/div_top.sv
verif/div_clk_gen.sv
verif/div_tb.sv

/* rtl/div_top.sv */
////////////////////
// RISC-V serial integer divider, top level
// operand preparation, restoring iteration core and controller
// issue_i with ex_stall_i low starts an operation, result on div_r_o
// while div_bubble_o is low
////////////////////

`timescale 1ns/1ps

module div_top
  import div_op_pkg::*;
  import div_cfg_pkg::*;
#(
  parameter int MXLEN = DIV_XLEN_DEFAULT
)
(
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             issue_i,
  input  div_op_e          op_i,
  input  logic [MXLEN-1:0] opa_i,
  input  logic [MXLEN-1:0] opb_i,

  input  logic             ex_stall_i,
  input  logic             mem_stall_i,

  output logic [MXLEN-1:0] div_r_o,
  output logic             div_bubble_o,
  output logic             div_stall_o
);

  logic             special;
  logic [MXLEN-1:0] special_val;
  logic             neg_q;
  logic             neg_r;
  logic [MXLEN-1:0] dividend;
  logic [MXLEN-1:0] divisor;
  logic             start;
  logic             last;
  logic [MXLEN-1:0] quotient;
  logic [MXLEN-1:0] remainder;

  div_prep #(.MXLEN(MXLEN)) div_prep_i (
    .op_i          (op_i),
    .opa_i         (opa_i),
    .opb_i         (opb_i),
    .special_o     (special),
    .special_val_o (special_val),
    .neg_q_o       (neg_q),
    .neg_r_o       (neg_r),
    .dividend_o    (dividend),
    .divisor_o     (divisor)
  );

  div_core #(.MXLEN(MXLEN)) div_core_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start),
    .dividend_i  (dividend),
    .divisor_i   (divisor),
    .last_o      (last),
    .quotient_o  (quotient),
    .remainder_o (remainder)
  );

  div_ctrl #(.MXLEN(MXLEN)) div_ctrl_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue_i),
    .ex_stall_i    (ex_stall_i),
    .mem_stall_i   (mem_stall_i),
    .op_i          (op_i),
    .special_i     (special),
    .special_val_i (special_val),
    .neg_q_i       (neg_q),
    .neg_r_i       (neg_r),
    .last_i        (last),
    .quotient_i    (quotient),
    .remainder_i   (remainder),
    .start_o       (start),
    .div_r_o       (div_r_o),
    .div_bubble_o  (div_bubble_o),
    .div_stall_o   (div_stall_o)
  );

endmodule

/* verif/div_clk_gen.sv */
////////////////////
// testbench clock and reset source
// free running clock, reset held low for RST_CYCLES rising edges
////////////////////

`timescale 1ns/1ps

module div_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 5
)
(
  output logic clk_o,
  output logic rst_no
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1; // release clear of the edge
  end

endmodule

/* verif/div_tb.sv */
////////////////////
// table driven testbench for the serial divider
// directed corner cases plus seeded random entries, checks value,
// latency, stall and bubble behavior, watchdog bounds the run
////////////////////

`timescale 1ns/1ps

module div_tb
  import div_op_pkg::*;
  import div_cfg_pkg::*;
;

  localparam int MXLEN      = DIV_XLEN_DEFAULT;
  localparam int RST_CYCLES = 5;
  localparam int DRV        = 2;  // drive delay after rising edge, ns
  localparam int EX_HOLD    = 3;
  localparam int MEM_HOLD   = 3;
  localparam int N_DIR      = 20;
  localparam int N_TOTAL    = 36;
  localparam int WD_CYCLES  = N_TOTAL * (MXLEN + 10) + RST_CYCLES + 10;
  localparam logic [MXLEN-1:0] MIN_NEG = {1'b1, {(MXLEN-1){1'b0}}};

  typedef struct packed {
    div_op_e          op;
    logic [MXLEN-1:0] a;
    logic [MXLEN-1:0] b;
    logic [MXLEN-1:0] exp;
    logic             exs; // hold ex_stall_i over the issue
    logic             mst; // hold mem_stall_i into the result state
  } entry_t;

  logic             clk_i;
  logic             rst_ni;
  logic             issue_i;
  div_op_e          op_i;
  logic [MXLEN-1:0] opa_i;
  logic [MXLEN-1:0] opb_i;
  logic             ex_stall_i;
  logic             mem_stall_i;
  logic [MXLEN-1:0] div_r_o;
  logic             div_bubble_o;
  logic             div_stall_o;

  entry_t tbl [N_TOTAL];
  integer seed;
  int     val_errs;
  int     proto_errs;

  div_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(RST_CYCLES)) div_clk_gen_i (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  div_top #(.MXLEN(MXLEN)) div_top_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue_i),
    .op_i         (op_i),
    .opa_i        (opa_i),
    .opb_i        (opb_i),
    .ex_stall_i   (ex_stall_i),
    .mem_stall_i  (mem_stall_i),
    .div_r_o      (div_r_o),
    .div_bubble_o (div_bubble_o),
    .div_stall_o  (div_stall_o)
  );

  ////////////////////
  // reference model
  ////////////////////

  // truncating quotient, remainder follows dividend sign
  function automatic logic [MXLEN-1:0] ref_result(div_op_e op, logic [MXLEN-1:0] a,
                                                   logic [MXLEN-1:0] b);
    logic rem;
    logic uns;
    rem = op[OP_REM_BIT];
    uns = op[OP_UNSIGNED_BIT];
    if (b == '0) return rem ? a : '1;
    if (!uns && a == MIN_NEG && &b) return rem ? '0 : a;
    if (uns) return rem ? (a % b) : (a / b);
    return rem ? ($signed(a) % $signed(b)) : ($signed(a) / $signed(b));
  endfunction

  task automatic set_entry(input int idx, input div_op_e op, input logic [MXLEN-1:0] a,
                           input logic [MXLEN-1:0] b, input logic [MXLEN-1:0] exp,
                           input logic exs, input logic mst);
    tbl[idx] = '{op: op, a: a, b: b, exp: exp, exs: exs, mst: mst};
  endtask

  task automatic build_table();
    logic [31:0]      r;
    logic [MXLEN-1:0] a;
    logic [MXLEN-1:0] b;
    div_op_e          op;
    // signed, all four sign combinations (20 and 3)
    set_entry(0,  OP_DIV,  32'h0000_0014, 32'h0000_0003, 32'h0000_0006, 0, 0);
    set_entry(1,  OP_DIV,  32'hFFFF_FFEC, 32'h0000_0003, 32'hFFFF_FFFA, 0, 0);
    set_entry(2,  OP_DIV,  32'h0000_0014, 32'hFFFF_FFFD, 32'hFFFF_FFFA, 0, 0);
    set_entry(3,  OP_DIV,  32'hFFFF_FFEC, 32'hFFFF_FFFD, 32'h0000_0006, 0, 0);
    set_entry(4,  OP_REM,  32'h0000_0014, 32'h0000_0003, 32'h0000_0002, 0, 0);
    set_entry(5,  OP_REM,  32'hFFFF_FFEC, 32'h0000_0003, 32'hFFFF_FFFE, 0, 0);
    set_entry(6,  OP_REM,  32'h0000_0014, 32'hFFFF_FFFD, 32'h0000_0002, 0, 0);
    set_entry(7,  OP_REM,  32'hFFFF_FFEC, 32'hFFFF_FFFD, 32'hFFFF_FFFE, 0, 0);
    set_entry(8,  OP_DIV,  32'h8000_0000, 32'h0000_0002, 32'hC000_0000, 0, 0);
    // unsigned with the top bit set
    set_entry(9,  OP_DIVU, 32'hFFFF_FFEC, 32'h0000_0003, 32'h5555_554E, 0, 0);
    set_entry(10, OP_REMU, 32'hFFFF_FFEC, 32'h0000_0003, 32'h0000_0002, 0, 0);
    set_entry(11, OP_DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 0, 0);
    set_entry(12, OP_REMU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 0, 0);
    // divide by zero and signed overflow
    set_entry(13, OP_DIV,  32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF, 0, 0);
    set_entry(14, OP_REM,  32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 0, 0);
    set_entry(15, OP_DIVU, 32'hFFFF_FFEC, 32'h0000_0000, 32'hFFFF_FFFF, 0, 0);
    set_entry(16, OP_DIV,  32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 0, 0);
    set_entry(17, OP_REM,  32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 0, 0);
    // back-pressure from both stall inputs
    set_entry(18, OP_DIV,  32'h0000_0064, 32'h0000_0007, 32'h0000_000E, 0, 1);
    set_entry(19, OP_REMU, 32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 1, 0);
    seed = 32'h6622_476a;
    for (int i = N_DIR; i < N_TOTAL; i++)
    begin
      r  = $random(seed);
      a  = $random(seed);
      b  = $random(seed);
      op = div_op_e'(r[1:0]);
      if (r[5:3] == 3'd0) b = '0;
      else if (r[8:6] < 3'd3) b = b >> 20; // small divisors, big quotients
      set_entry(i, op, a, b, ref_result(op, a, b), 1'b0, r[12:10] == 3'd0);
    end
  endtask

  ////////////////////
  // one table entry
  ////////////////////

  task automatic run_entry(input int idx);
    entry_t e;
    logic   special;
    int     cycles;
    int     exp_lat;
    e       = tbl[idx];
    special = (e.b == '0) || (!e.op[OP_UNSIGNED_BIT] && e.a == MIN_NEG && &e.b);
    exp_lat = special ? 0 : (e.mst ? MXLEN + 1 + MEM_HOLD : MXLEN + 1);
    issue_i     = 1'b1;
    op_i        = e.op;
    opa_i       = e.a;
    opb_i       = e.b;
    ex_stall_i  = e.exs;
    mem_stall_i = e.mst;
    if (e.exs)
    begin
      repeat (EX_HOLD)
      begin
        @(posedge clk_i);
        #DRV;
        if (!div_bubble_o || div_stall_o)
        begin
          proto_errs++;
          $display("entry %0d: issue was taken while ex_stall_i was high", idx);
        end
      end
      ex_stall_i = 1'b0;
    end
    @(posedge clk_i); // accepting edge
    #DRV;
    issue_i = 1'b0;
    cycles  = 0;
    while (div_bubble_o && cycles <= MXLEN + MEM_HOLD + 4)
    begin
      if (div_stall_o !== !special)
      begin
        proto_errs++;
        $display("entry %0d: stall level wrong %0d cycles after issue", idx, cycles);
      end
      if (e.mst && cycles == MXLEN + MEM_HOLD) mem_stall_i = 1'b0; // release
      @(posedge clk_i);
      #DRV;
      cycles++;
    end
    mem_stall_i = 1'b0;
    if (div_bubble_o)
    begin
      proto_errs++;
      $display("entry %0d: no result, bubble never went low", idx);
    end
    else
    begin
      if (div_r_o !== e.exp)
      begin
        val_errs++;
        $display("** Error: div_r_o entry %0d got %h expected %h", idx, div_r_o, e.exp);
      end
      if (cycles != exp_lat)
      begin
        proto_errs++;
        $display("entry %0d: result after %0d cycles instead of %0d", idx, cycles, exp_lat);
      end
      if (div_stall_o)
      begin
        proto_errs++;
        $display("entry %0d: stall still high while result is valid", idx);
      end
    end
    @(posedge clk_i);
    #DRV;
    if (!div_bubble_o)
    begin
      proto_errs++;
      $display("entry %0d: bubble low for more than one cycle", idx);
    end
  endtask

  ////////////////////
  // main sequence and watchdog
  ////////////////////

  initial
  begin
    issue_i     = 1'b0;
    op_i        = OP_DIV;
    opa_i       = '0;
    opb_i       = '0;
    ex_stall_i  = 1'b0;
    mem_stall_i = 1'b0;
    val_errs    = 0;
    proto_errs  = 0;
    build_table();
    wait (rst_ni);
    @(posedge clk_i);
    #DRV;
    if (div_bubble_o !== 1'b1)
    begin
      val_errs++;
      $display("** Error: div_bubble_o after reset got %h expected 1", div_bubble_o);
    end
    if (div_stall_o !== 1'b0)
    begin
      val_errs++;
      $display("** Error: div_stall_o after reset got %h expected 0", div_stall_o);
    end
    for (int i = 0; i < N_TOTAL; i++) run_entry(i);
    $display("div_tb: %0d entries, %0d value errors, %0d protocol errors",
             N_TOTAL, val_errs, proto_errs);
    if (val_errs + proto_errs == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
    $display("div_tb: %0d value errors, %0d protocol errors", val_errs, proto_errs);
    $display("Simulation failed");
    $finish;
  end

endmodule
